// File: cn_node.f
+incdir+rtl
rtl/cn_cfg_pkg.sv
rtl/cn_neuro_pkg.sv
rtl/cn_param_bank.sv
rtl/cn_tick_gen.sv
rtl/cn_button_gain.sv
rtl/cn_synapse.sv
rtl/cn_drive_mixer.sv
rtl/cn_spiking_neuron.sv
rtl/cn_node_top.sv
sim/tb_cn_node.sv

// File: rtl/cn_button_gain.sv
`include "cn_defines.svh"

module cn_button_gain (
    input  logic        ep50trig,
    input  logic        reset_global,
    input  logic        i_gain_button,
    output logic [3:0]  o_gain_step
);

    logic       btn_meta;   // first sync stage
    logic       btn_sync;
    logic       btn_prev;   // last seen synchronized level
    logic       btn_change;
    logic [3:0] pre_cnt;

    // two-flop synchronizer plus history flop
    always_ff @(posedge ep50trig or posedge reset_global) begin
        if (reset_global) begin
            btn_meta <= 1'b0;
            btn_sync <= 1'b0;
            btn_prev <= 1'b0;
        end else begin
            btn_meta <= i_gain_button;
            btn_sync <= btn_meta;
            btn_prev <= btn_sync;
        end
    end

    assign btn_change = btn_sync ^ btn_prev;   // both press and release count

    // pre-count wraps after the max, so the step runs 0..7
    always_ff @(posedge ep50trig or posedge reset_global) begin
        if (reset_global) begin
            pre_cnt <= '0;
        end else if (btn_change) begin
            if (pre_cnt == 4'(`CN_GAIN_PRE_MAX)) begin
                pre_cnt <= '0;
            end else begin
                pre_cnt <= pre_cnt + 4'd1;
            end
        end
    end

    assign o_gain_step = pre_cnt >> 1;   // three cycles after the pin edge

endmodule

// File: rtl/cn_cfg_pkg.sv
`include "cn_defines.svh"

package cn_cfg_pkg;

    // trigger bit of each host parameter
    typedef enum logic [$clog2(`CN_TRIG_W)-1:0] {
        GAIN_IA    = 1,
        GAIN_II    = 2,
        SYN_GAIN   = 3,     // reserved slot, never stored
        OVERFLOW   = 4,
        OFFSET     = 6,
        CLK_DIV    = 7,
        EXTRA1     = 8,
        EXTRA2     = 9,
        EXTRA_GAIN = 13     // gain on combined sensory current
    } cn_param_sel_e;

    // everything the host can load
    typedef struct packed {
        logic [`CN_DATA_W-1:0] gain_ia;         // Q16.16
        logic [`CN_DATA_W-1:0] gain_ii;         // Q16.16
        logic [`CN_DATA_W-1:0] extra_gain;      // Q16.16
        logic [`CN_DATA_W-1:0] overflow_prop;   // Q16.16, 0.0 to 1.0
        logic [`CN_DATA_W-1:0] offset;
        logic [`CN_DATA_W-1:0] clk_div;         // cycles per neuron step
        logic [`CN_DATA_W-1:0] extra1;
        logic [`CN_DATA_W-1:0] extra2;
    } cn_params_t;

endpackage

// File: rtl/cn_defines.svh
`ifndef CN_DEFINES_SVH
`define CN_DEFINES_SVH

// datapath and host bus widths
`define CN_DATA_W           32
`define CN_TRIG_W           16          // strobe bank from the host
`define CN_FRAC_W           16          // gains and proportions are Q16.16

`define CN_ONE              32'h0001_0000   // 1.0 in Q16.16

// reset values
`define CN_CLKDIV_RST       381         // real time speed

// step rates and scaling
`define CN_NEURON_STEPS     16          // neuron steps per sim step
`define CN_COMP_SHIFT       9           // neuron compensation of the sensory path
`define CN_EXTRA1_SHIFT     4           // tonic cortical drive scaling

// synapse
`define CN_SYN_WEIGHT       1000        // current per caught spike
`define CN_SYN_DECAY_SHIFT  3           // decay of 1/8 per sim step

// neuron
`define CN_INPUT_SHIFT      6
`define CN_THRESHOLD        (30 << 10)  // 30 mV scaled

// button stepper
`define CN_GAIN_PRE_MAX     14

`endif

// File: rtl/cn_drive_mixer.sv
`include "cn_defines.svh"

module cn_drive_mixer (
    input  logic                        ep50trig,
    input  logic                        reset_global,
    input  logic                        i_reset_sim,
    input  logic                        i_sim_tick,
    input  cn_cfg_pkg::cn_params_t      i_params,
    input  logic [`CN_DATA_W-1:0]       i_current_ia,
    input  logic [`CN_DATA_W-1:0]       i_current_ii,
    input  logic [3:0]                  i_gain_step,
    output cn_neuro_pkg::cn_drive_t     o_drive,
    output logic [`CN_DATA_W-1:0]       o_gain_scaled_drive
);

    localparam int W  = `CN_DATA_W;
    localparam int WW = 2 * `CN_DATA_W;   // full product width

    logic [WW-1:0] prod_ia;
    logic [WW-1:0] prod_ii;
    logic [WW:0]   sens_wide;       // carry bit of the sum
    logic [W-1:0]  sens_sum;
    logic [WW-1:0] prod_extra;
    logic [W-1:0]  comp_drive;      // sensory part after compensation
    logic [W-1:0]  raw_drive;
    logic [W-1:0]  drive_latched;
    logic [W-1:0]  main_drive;
    logic [WW-1:0] prod_ovf;

    // afferent gains in Q16.16
    assign prod_ia   = WW'(i_current_ia) * WW'(i_params.gain_ia);
    assign prod_ii   = WW'(i_current_ii) * WW'(i_params.gain_ii);
    assign sens_wide = {1'b0, prod_ia} + {1'b0, prod_ii};
    assign sens_sum  = sens_wide[`CN_FRAC_W +: W];     // back to integer

    // combined sensory gain, then compensate for neuron input shift
    assign prod_extra = WW'(sens_sum) * WW'(i_params.extra_gain);
    assign comp_drive = prod_extra[`CN_FRAC_W +: W] << `CN_COMP_SHIFT;

    // tonic cortical drive on top
    assign raw_drive = comp_drive
                     + (i_params.extra1 << `CN_EXTRA1_SHIFT)
                     + i_params.extra2;

    // one drive value per simulated ms
    always_ff @(posedge ep50trig or posedge reset_global) begin
        if (reset_global) begin
            drive_latched <= '0;
        end else if (i_reset_sim) begin
            drive_latched <= '0;
        end else if (i_sim_tick) begin
            drive_latched <= raw_drive;
        end
    end

    // offset with floor at zero
    assign main_drive = (drive_latched > i_params.offset) ?
                        drive_latched - i_params.offset : '0;

    // overflow neuron sees a proportion of the main drive
    assign prod_ovf = WW'(main_drive) * WW'(i_params.overflow_prop);

    assign o_drive.main     = main_drive;
    assign o_drive.overflow = prod_ovf[`CN_FRAC_W +: W];

    // button scaled sensory drive, monitor only
    assign o_gain_scaled_drive = comp_drive * W'(i_gain_step);

endmodule

// File: rtl/cn_neuro_pkg.sv
`include "cn_defines.svh"

package cn_neuro_pkg;

    // step strobes on ep50trig
    typedef struct packed {
        logic neuron;   // one neuron integration step
        logic sim;      // one simulated ms
    } cn_ticks_t;

    // drives into the two neurons
    typedef struct packed {
        logic [`CN_DATA_W-1:0] main;
        logic [`CN_DATA_W-1:0] overflow;
    } cn_drive_t;

    // neuron FSM
    typedef enum logic {
        INTEGRATE,
        REFRACTORY
    } cn_neuron_state_e;

endpackage

// File: rtl/cn_node_top.sv
`include "cn_defines.svh"

module cn_node_top (
    input  logic                        ep50trig,
    input  logic                        reset_global,
    input  logic                        i_reset_sim,
    input  logic [`CN_TRIG_W-1:0]       i_trig,
    input  logic [`CN_DATA_W/2-1:0]     i_wire_hi,
    input  logic [`CN_DATA_W/2-1:0]     i_wire_lo,
    input  logic                        i_spike_ia,     // spindle Ia afferent
    input  logic                        i_spike_ii,     // spindle II afferent
    input  logic                        i_gain_button,
    output logic [`CN_DATA_W-1:0]       o_drive_main,
    output logic [`CN_DATA_W-1:0]       o_drive_overflow,
    output logic [`CN_DATA_W-1:0]       o_gain_scaled_drive,
    output logic [3:0]                  o_gain_step,
    output logic                        o_spike_main,
    output logic                        o_spike_overflow
);

    import cn_cfg_pkg::*;
    import cn_neuro_pkg::*;

    cn_params_t              params;
    cn_ticks_t               ticks;
    cn_drive_t               drive;
    logic [`CN_DATA_W-1:0]   current_ia;
    logic [`CN_DATA_W-1:0]   current_ii;

    cn_param_bank i_param_bank (
        .ep50trig     (ep50trig),
        .reset_global (reset_global),
        .i_trig       (i_trig),
        .i_wire_hi    (i_wire_hi),
        .i_wire_lo    (i_wire_lo),
        .o_params     (params)
    );

    cn_tick_gen i_tick_gen (
        .ep50trig     (ep50trig),
        .reset_global (reset_global),
        .i_reset_sim  (i_reset_sim),
        .i_clk_div    (params.clk_div),
        .o_ticks      (ticks)
    );

    cn_button_gain i_button_gain (
        .ep50trig      (ep50trig),
        .reset_global  (reset_global),
        .i_gain_button (i_gain_button),
        .o_gain_step   (o_gain_step)
    );

    cn_synapse i_synapse_ia (
        .ep50trig     (ep50trig),
        .reset_global (reset_global),
        .i_reset_sim  (i_reset_sim),
        .i_sim_tick   (ticks.sim),
        .i_spike      (i_spike_ia),
        .o_current    (current_ia)
    );

    cn_synapse i_synapse_ii (
        .ep50trig     (ep50trig),
        .reset_global (reset_global),
        .i_reset_sim  (i_reset_sim),
        .i_sim_tick   (ticks.sim),
        .i_spike      (i_spike_ii),
        .o_current    (current_ii)
    );

    cn_drive_mixer i_drive_mixer (
        .ep50trig            (ep50trig),
        .reset_global        (reset_global),
        .i_reset_sim         (i_reset_sim),
        .i_sim_tick          (ticks.sim),
        .i_params            (params),
        .i_current_ia        (current_ia),
        .i_current_ii        (current_ii),
        .i_gain_step         (o_gain_step),
        .o_drive             (drive),
        .o_gain_scaled_drive (o_gain_scaled_drive)
    );

    // main CN neuron
    cn_spiking_neuron i_neuron_main (
        .ep50trig      (ep50trig),
        .reset_global  (reset_global),
        .i_reset_sim   (i_reset_sim),
        .i_neuron_tick (ticks.neuron),
        .i_drive       (drive.main),
        .o_spike       (o_spike_main)
    );

    // overflow neuron on the scaled drive
    cn_spiking_neuron i_neuron_overflow (
        .ep50trig      (ep50trig),
        .reset_global  (reset_global),
        .i_reset_sim   (i_reset_sim),
        .i_neuron_tick (ticks.neuron),
        .i_drive       (drive.overflow),
        .o_spike       (o_spike_overflow)
    );

    assign o_drive_main     = drive.main;
    assign o_drive_overflow = drive.overflow;

endmodule

// File: rtl/cn_param_bank.sv
`include "cn_defines.svh"

module cn_param_bank (
    input  logic                        ep50trig,
    input  logic                        reset_global,
    input  logic [`CN_TRIG_W-1:0]       i_trig,         // one-cycle load strobes
    input  logic [`CN_DATA_W/2-1:0]     i_wire_hi,
    input  logic [`CN_DATA_W/2-1:0]     i_wire_lo,
    output cn_cfg_pkg::cn_params_t      o_params
);

    import cn_cfg_pkg::*;

    logic [`CN_DATA_W-1:0] host_word;

    assign host_word = {i_wire_hi, i_wire_lo};  // hi half on top

    // one register per parameter, each loaded by its own strobe bit
    // unlisted bits and the syn gain slot fall through untouched
    always_ff @(posedge ep50trig or posedge reset_global) begin
        if (reset_global) begin
            o_params.gain_ia       <= `CN_ONE;
            o_params.gain_ii       <= `CN_ONE;
            o_params.extra_gain    <= `CN_ONE;
            o_params.overflow_prop <= `CN_ONE;     // full drive to overflow neuron
            o_params.offset        <= '0;
            o_params.clk_div       <= `CN_DATA_W'(`CN_CLKDIV_RST);
            o_params.extra1        <= '0;
            o_params.extra2        <= '0;
        end else begin
            if (i_trig[GAIN_IA]) begin
                o_params.gain_ia <= host_word;
            end
            if (i_trig[GAIN_II]) begin
                o_params.gain_ii <= host_word;
            end
            if (i_trig[EXTRA_GAIN]) begin
                o_params.extra_gain <= host_word;
            end
            if (i_trig[OVERFLOW]) begin
                o_params.overflow_prop <= host_word;
            end
            if (i_trig[OFFSET]) begin
                o_params.offset <= host_word;
            end
            if (i_trig[CLK_DIV]) begin
                o_params.clk_div <= host_word;   // takes effect on next count
            end
            if (i_trig[EXTRA1]) begin
                o_params.extra1 <= host_word;
            end
            if (i_trig[EXTRA2]) begin
                o_params.extra2 <= host_word;    // was the wave pipe source
            end
        end
    end

endmodule

// File: rtl/cn_spiking_neuron.sv
`include "cn_defines.svh"

module cn_spiking_neuron (
    input  logic                    ep50trig,
    input  logic                    reset_global,
    input  logic                    i_reset_sim,
    input  logic                    i_neuron_tick,
    input  logic [`CN_DATA_W-1:0]   i_drive,
    output logic                    o_spike
);

    import cn_neuro_pkg::*;

    localparam int W = `CN_DATA_W;

    cn_neuron_state_e state;
    logic [W-1:0]     v;          // membrane potential, scaled
    logic [W-1:0]     v_sum;
    logic             at_thresh;

    assign v_sum     = v + (i_drive >> `CN_INPUT_SHIFT);
    assign at_thresh = (v_sum >= W'(`CN_THRESHOLD));

    always_ff @(posedge ep50trig or posedge reset_global) begin
        if (reset_global) begin
            state   <= INTEGRATE;
            v       <= '0;
            o_spike <= 1'b0;
        end else if (i_reset_sim) begin
            state   <= INTEGRATE;
            v       <= '0;
            o_spike <= 1'b0;
        end else begin
            o_spike <= 1'b0;   // pulse lasts a single cycle
            if (i_neuron_tick) begin
                case (state)
                    INTEGRATE: begin
                        if (at_thresh) begin
                            v       <= '0;   // fire and reset potential
                            o_spike <= 1'b1;
                            state   <= REFRACTORY;
                        end else begin
                            v <= v_sum;
                        end
                    end
                    REFRACTORY: begin
                        state <= INTEGRATE;  // skip one step of input
                    end
                    default: begin
                        state <= INTEGRATE;
                    end
                endcase
            end
        end
    end

endmodule

// File: rtl/cn_synapse.sv
`include "cn_defines.svh"

module cn_synapse (
    input  logic                    ep50trig,
    input  logic                    reset_global,
    input  logic                    i_reset_sim,
    input  logic                    i_sim_tick,
    input  logic                    i_spike,
    output logic [`CN_DATA_W-1:0]   o_current
);

    localparam int W = `CN_DATA_W;

    logic         pending;      // spike seen since the last sim tick
    logic [W-1:0] spike_add;

    assign spike_add = pending ? W'(`CN_SYN_WEIGHT) : '0;

    always_ff @(posedge ep50trig or posedge reset_global) begin
        if (reset_global) begin
            pending   <= 1'b0;
            o_current <= '0;
        end else if (i_reset_sim) begin
            pending   <= 1'b0;
            o_current <= '0;
        end else if (i_sim_tick) begin
            // exponential decay then the weight of a caught spike
            o_current <= o_current - (o_current >> `CN_SYN_DECAY_SHIFT) + spike_add;
            pending   <= i_spike;   // a spike on the tick itself goes to the next step
        end else if (i_spike) begin
            pending <= 1'b1;
        end
    end

endmodule

// File: rtl/cn_tick_gen.sv
`include "cn_defines.svh"

module cn_tick_gen (
    input  logic                    ep50trig,
    input  logic                    reset_global,
    input  logic                    i_reset_sim,
    input  logic [`CN_DATA_W-1:0]   i_clk_div,
    output cn_neuro_pkg::cn_ticks_t o_ticks
);

    localparam int W      = `CN_DATA_W;
    localparam int STEP_W = $clog2(`CN_NEURON_STEPS);

    logic [W-1:0]      cyc_cnt;    // cycles within a neuron step
    logic [STEP_W-1:0] step_cnt;   // neuron steps within a sim step
    logic [W-1:0]      div_eff;
    logic              cyc_wrap;
    logic              step_last;

    assign div_eff   = (i_clk_div == '0) ? W'(1) : i_clk_div;  // 0 acts as 1
    // >= so a smaller divider loaded mid-count wraps at once
    assign cyc_wrap  = (cyc_cnt >= div_eff - W'(1));
    assign step_last = (step_cnt == STEP_W'(`CN_NEURON_STEPS - 1));

    always_ff @(posedge ep50trig or posedge reset_global) begin
        if (reset_global) begin
            cyc_cnt  <= '0;
            step_cnt <= '0;
            o_ticks  <= '0;
        end else if (i_reset_sim) begin
            cyc_cnt  <= '0;
            step_cnt <= '0;
            o_ticks  <= '0;
        end else begin
            o_ticks.neuron <= cyc_wrap;
            o_ticks.sim    <= cyc_wrap && step_last;   // rides on the last neuron strobe
            if (cyc_wrap) begin
                cyc_cnt  <= '0;
                step_cnt <= step_last ? '0 : step_cnt + STEP_W'(1);
            end else begin
                cyc_cnt <= cyc_cnt + W'(1);
            end
        end
    end

endmodule

// File: run_sim.sh
#!/usr/bin/env bash
# build and run the cn_node testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ps \
    -f cn_node.f --top-module tb_cn_node -o tb_cn_node

out="$(./obj_dir/tb_cn_node)"
echo "$out"

if echo "$out" | grep -q "^TEST RESULT: PASS$"; then
    exit 0
else
    exit 1
fi

// File: sim/tb_cn_node.sv
`include "cn_defines.svh"

module tb_cn_node;

    timeunit 1ns;
    timeprecision 1ps;

    import cn_cfg_pkg::*;

    localparam int TIMEOUT_CYC = 400;   // sim step is 32 cycles at clk_div 2

    logic                  ep50trig;
    logic                  reset_global;
    logic                  i_reset_sim;
    logic [`CN_TRIG_W-1:0] i_trig;
    logic [15:0]           i_wire_hi;
    logic [15:0]           i_wire_lo;
    logic                  i_spike_ia;
    logic                  i_spike_ii;
    logic                  i_gain_button;
    logic [31:0]           o_drive_main;
    logic [31:0]           o_drive_overflow;
    logic [31:0]           o_gain_scaled_drive;
    logic [3:0]            o_gain_step;
    logic                  o_spike_main;
    logic                  o_spike_overflow;

    int    errors = 0;
    int    tests_run = 0;
    int    tests_failed = 0;
    int    gap = 100;              // cycles since the last main spike
    logic  ovf_quiet = 1'b0;       // overflow neuron must stay silent
    string test_name = "reset";

    cn_node_top i_cn_node_top (.*);

    always #10 ep50trig = ~ep50trig;

    // spikes are single-cycle pulses
    assert property (@(posedge ep50trig) disable iff (reset_global)
                     o_spike_main |=> !o_spike_main)
        else begin
            $display("o_spike_main stayed high for more than one cycle in test %s", test_name);
            errors++;
        end

    assert property (@(posedge ep50trig) disable iff (!ovf_quiet) !o_spike_overflow)
        else begin
            $display("overflow neuron fired with a zero proportion in test %s", test_name);
            errors++;
        end

    // refractory step: next spike at least two neuron ticks later
    always @(negedge ep50trig) begin
        if (reset_global || i_reset_sim) begin
            gap <= 100;
        end else if (o_spike_main) begin
            assert (gap >= 4) else begin
                $display("main neuron fired %0d cycles after its last spike in test %s",
                         gap, test_name);
                errors++;
            end
            gap <= 1;
        end else begin
            gap <= gap + 1;
        end
    end

    task automatic check(input string what, input logic [31:0] expected,
                         input logic [31:0] actual);
        assert (actual === expected) else begin
            $display("MISMATCH %s: %s expected %0d actual %0d", test_name, what,
                     expected, actual);
            errors++;
        end
    endtask

    task automatic write_param(input cn_param_sel_e sel, input logic [31:0] value);
        @(negedge ep50trig);
        i_trig                 = `CN_TRIG_W'(1) << sel;   // one strobe bit
        {i_wire_hi, i_wire_lo} = value;
        @(negedge ep50trig);
        i_trig = '0;
    endtask

    // returns one cycle after the sim pulse, latch already loaded
    task automatic wait_sim_tick();
        int n = 0;
        do begin
            @(negedge ep50trig);
            n++;
        end while (!i_cn_node_top.ticks.sim && n < TIMEOUT_CYC);
        if (!i_cn_node_top.ticks.sim) begin
            $display("no sim tick within %0d cycles in test %s", TIMEOUT_CYC, test_name);
            errors++;
        end
        @(negedge ep50trig);
    endtask

    task automatic wait_spike_main();
        int n = 0;
        while (!o_spike_main && n < TIMEOUT_CYC) begin
            @(negedge ep50trig);
            n++;
        end
        if (!o_spike_main) begin
            $display("main neuron never fired in test %s", test_name);
            errors++;
        end
    endtask

    task automatic finish_test(input int errors_before);
        tests_run++;
        if (errors != errors_before) begin
            tests_failed++;
            $display("test %s failed, %0d errors", test_name, errors - errors_before);
        end else begin
            $display("test %s passed", test_name);
        end
    endtask

    // sensory path of the mixer, from the gain rules
    function automatic logic [31:0] sensory_drive(input logic [31:0] ia, input logic [31:0] ii,
                                                  input logic [31:0] gia, input logic [31:0] gii);
        logic [64:0] sum;
        logic [63:0] scaled;
        sum    = 65'(64'(ia) * 64'(gia)) + 65'(64'(ii) * 64'(gii));
        scaled = 64'(32'(sum >> `CN_FRAC_W)) * 64'(`CN_ONE);   // extra gain left at 1.0
        return 32'(scaled >> `CN_FRAC_W) << `CN_COMP_SHIFT;
    endfunction

    initial begin
        int          start;
        int          total;
        int          n;
        logic [31:0] e1;
        logic [31:0] e2;
        logic [31:0] base;
        logic [31:0] off;
        logic [31:0] prop;
        logic [31:0] cur_ia;
        logic [31:0] cur_ii;
        logic [31:0] gstep;
        logic        pend_ia;
        logic        pend_ii;
        ep50trig      = 1'b0;
        reset_global  = 1'b1;
        i_reset_sim   = 1'b0;
        i_trig        = '0;
        i_wire_hi     = '0;
        i_wire_lo     = '0;
        i_spike_ia    = 1'b0;
        i_spike_ii    = 1'b0;
        i_gain_button = 1'b0;
        start = $urandom(35);              // fixed seed
        repeat (10) @(negedge ep50trig);
        reset_global = 1'b0;
        start = errors;
        @(negedge ep50trig);
        check("main spike", 0, 32'(o_spike_main));
        check("overflow spike", 0, 32'(o_spike_overflow));
        check("main drive", 0, o_drive_main);
        check("overflow drive", 0, o_drive_overflow);
        check("gain step", 0, 32'(o_gain_step));
        finish_test(start);

        test_name = "extra_offset";
        start = errors;
        write_param(CLK_DIV, 32'd2);        // short sim steps
        e1 = $urandom % 32'h1_0000;
        e2 = $urandom % 32'h10_0000;
        write_param(EXTRA1, e1);
        write_param(EXTRA2, e2);
        wait_sim_tick();
        base = (e1 << `CN_EXTRA1_SHIFT) + e2;
        check("main drive", base, o_drive_main);
        write_param(OFFSET, base + 1 + ($urandom % 100));
        check("main drive below offset", 0, o_drive_main);
        off = $urandom % (base + 1);
        write_param(OFFSET, off);
        check("main drive minus offset", base - off, o_drive_main);
        finish_test(start);

        test_name = "overflow";
        start = errors;
        prop = $urandom % (`CN_ONE + 1);
        write_param(OVERFLOW, prop);
        check("overflow drive", 32'((64'(base - off) * 64'(prop)) >> `CN_FRAC_W),
              o_drive_overflow);
        write_param(OVERFLOW, 32'd0);
        check("overflow drive at zero proportion", 0, o_drive_overflow);
        finish_test(start);

        test_name = "button_gain";
        start = errors;
        total = 0;
        repeat (4) begin
            n = 1 + int'($urandom % 20);
            repeat (n) begin
                @(negedge ep50trig);
                i_gain_button = ~i_gain_button;
                @(negedge ep50trig);
            end
            total += n;
            repeat (4) @(negedge ep50trig);     // step follows the edge by 3 cycles
            check("gain step", 32'((total % 15) >> 1), 32'(o_gain_step));
        end
        finish_test(start);

        test_name = "synapse";
        start = errors;
        write_param(EXTRA1, 32'd0);
        write_param(EXTRA2, 32'd0);
        write_param(OFFSET, 32'd0);
        write_param(GAIN_IA, 32'h0002_0000);   // 2.0
        write_param(GAIN_II, 32'h0000_8000);   // 0.5
        // a zero step would hide the gain-scaled drive
        while (((total % 15) >> 1) == 0) begin
            @(negedge ep50trig);
            i_gain_button = ~i_gain_button;
            @(negedge ep50trig);
            total++;
        end
        gstep = 32'((total % 15) >> 1);
        wait_sim_tick();
        cur_ia = '0;
        cur_ii = '0;
        for (int k = 0; k < 6; k++) begin
            pend_ia = 1'($urandom % 2);
            pend_ii = 1'($urandom % 2);
            @(negedge ep50trig);
            i_spike_ia = pend_ia;
            i_spike_ii = pend_ii;
            @(negedge ep50trig);
            i_spike_ia = 1'b0;
            i_spike_ii = 1'b0;
            wait_sim_tick();
            // latch saw the currents from before this tick
            check("main drive", sensory_drive(cur_ia, cur_ii, 32'h0002_0000, 32'h0000_8000),
                  o_drive_main);
            cur_ia = cur_ia - (cur_ia >> `CN_SYN_DECAY_SHIFT)
                   + (pend_ia ? 32'(`CN_SYN_WEIGHT) : 32'd0);
            cur_ii = cur_ii - (cur_ii >> `CN_SYN_DECAY_SHIFT)
                   + (pend_ii ? 32'(`CN_SYN_WEIGHT) : 32'd0);
            // monitor path follows the live currents
            check("gain scaled drive",
                  32'(sensory_drive(cur_ia, cur_ii, 32'h0002_0000, 32'h0000_8000) * gstep),
                  o_gain_scaled_drive);
        end
        finish_test(start);

        test_name = "spiking";
        start = errors;
        write_param(OVERFLOW, 32'd0);
        write_param(EXTRA2, 32'h0040_0000);    // above threshold in one neuron step
        repeat (2) @(negedge ep50trig);
        ovf_quiet = 1'b1;
        wait_sim_tick();
        wait_spike_main();
        @(negedge ep50trig);
        i_reset_sim = 1'b1;
        repeat (3) @(negedge ep50trig);
        check("main spike in sim reset", 0, 32'(o_spike_main));
        i_reset_sim = 1'b0;
        check("main drive after sim reset", 0, o_drive_main);
        n = 0;
        while (!i_cn_node_top.ticks.sim && n < TIMEOUT_CYC) begin
            assert (!o_spike_main) else begin
                $display("main neuron fired before the drive was rebuilt in test %s",
                         test_name);
                errors++;
            end
            @(negedge ep50trig);
            n++;
        end
        wait_spike_main();                     // drive back after the sim tick
        finish_test(start);

        $display("tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
        if (errors == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule
